//--- common/hio_pkg.sv
// shared host bridge definitions, imported by every block that decodes host words or opcodes
package hio_pkg;

	// host bus word
	localparam int HIO_W = 16;

	// payload index, saturates at all ones
	localparam int IDX_W = 10;

	// download address width
	localparam int IOCTL_AW = 25;

	// clk_sys cycles per ps2 half period
	localparam int PS2_DIV = 4;
	localparam int PS2_CNT_W = (PS2_DIV > 1) ? $clog2(PS2_DIV) : 1;

	// 8 entry byte fifo per ps2 channel
	localparam int PS2_FIFO_BITS = 3;

	// buttons and switches
	localparam logic [7:0] OP_CFG = 8'h01;

	// digital joysticks
	localparam logic [7:0] OP_JOY0 = 8'h02;
	localparam logic [7:0] OP_JOY1 = 8'h03;

	// ps2 byte streams
	localparam logic [7:0] OP_MOUSE = 8'h04;
	localparam logic [7:0] OP_KBD = 8'h05;

	// disk image handling
	localparam logic [7:0] OP_MOUNT = 8'h1C;
	localparam logic [7:0] OP_IMG_SIZE = 8'h1D;

	// 32 bit status, low half first
	localparam logic [7:0] OP_STATUS = 8'h1E;

	// keyboard led readback
	localparam logic [7:0] OP_KBD_LED = 8'h1F;

	// file download
	localparam logic [7:0] OP_FILE_TX = 8'h53;
	localparam logic [7:0] OP_FILE_DAT = 8'h54;
	localparam logic [7:0] OP_FILE_IDX = 8'h55;

	// first word of a frame is a command, later words are raw data
	typedef struct packed {
		logic [7:0] rsvd;
		logic [7:0] op;
	} hio_cmd_t;

	typedef union packed {
		hio_cmd_t cmd;
		logic [HIO_W-1:0] data;
	} hio_word_t;

endpackage

//--- verilog/hio_cmd_frame.sv
// host frame parser, splits each io_enable frame into a command and indexed payload words
module hio_cmd_frame (
	input logic clk_sys,
	input logic rst_n,
	input logic io_enable,
	input logic io_strobe,
	input logic [hio_pkg::HIO_W-1:0] io_din,
	output logic pay_valid,
	output logic frame_start,
	output logic [hio_pkg::HIO_W-1:0] pay_data,
	output logic [hio_pkg::IDX_W-1:0] pay_idx,
	output logic [7:0] opcode
);
	import hio_pkg::*;

	hio_word_t word_in;
	logic [IDX_W-1:0] word_cnt;

	// same bus word, viewed as command or data
	assign word_in.data = io_din;

	// frame state and command latch
	always_ff @(posedge clk_sys) begin
		if (!rst_n || !io_enable) begin
			word_cnt <= '0;
			opcode <= '0;
			pay_valid <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			pay_valid <= 1'b0;
			frame_start <= 1'b0;
			if (io_strobe) begin
				// saturate, long payloads keep the last index
				if (word_cnt != '1)
					word_cnt <= word_cnt + 1'b1;
				if (word_cnt == '0) begin
					opcode <= word_in.cmd.op;
					frame_start <= 1'b1;
				end else begin
					pay_valid <= 1'b1;
				end
			end
		end
	end

	// payload word and its index, qualified by pay_valid
	always_ff @(posedge clk_sys) begin
		if (io_strobe && word_cnt != '0) begin
			pay_data <= word_in.data;
			pay_idx <= word_cnt;
		end
	end

	// host may only strobe inside a frame
	a_strobe_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		io_strobe |-> io_enable);

endmodule

//--- verilog/hio_regs.sv
// core register block, decodes payload words into config, status, image and ps2 push requests
module hio_regs (
	input logic clk_sys,
	input logic rst_n,
	input logic pay_valid,
	input logic frame_start,
	input logic [hio_pkg::HIO_W-1:0] pay_data,
	input logic [hio_pkg::IDX_W-1:0] pay_idx,
	input logic [7:0] opcode,
	input logic [2:0] kbd_led_status,
	input logic [2:0] kbd_led_use,
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic img_mounted,
	output logic [15:0] joystick_0,
	output logic [15:0] joystick_1,
	output logic [31:0] status,
	output logic [63:0] img_size,
	output logic [15:0] io_dout,
	output logic kbd_push,
	output logic mouse_push,
	output logic [7:0] push_byte
);
	import hio_pkg::*;

	logic [15:0] led_word;

	// 0b01 then status/use pairs, bit 2 first
	assign led_word = {8'h00, 2'b01,
		kbd_led_status[2], kbd_led_use[2],
		kbd_led_status[1], kbd_led_use[1],
		kbd_led_status[0], kbd_led_use[0]};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			buttons <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
			img_size <= '0;
			img_mounted <= 1'b0;
			io_dout <= '0;
			kbd_push <= 1'b0;
			mouse_push <= 1'b0;
		end else begin
			// mount notify fires on the command word
			img_mounted <= frame_start && opcode == OP_MOUNT;
			kbd_push <= pay_valid && opcode == OP_KBD;
			mouse_push <= pay_valid && opcode == OP_MOUSE;
			// new frame drops any old read word
			if (frame_start)
				io_dout <= '0;
			if (pay_valid) begin
				// read word held until the next strobe
				io_dout <= (opcode == OP_KBD_LED) ? led_word : '0;
				case (opcode)
					OP_CFG: begin
						// cfg 3:2 and 7:5 belong to the frame wrapper
						buttons <= pay_data[1:0];
						forced_scandoubler <= pay_data[4];
					end
					OP_JOY0: joystick_0 <= pay_data;
					OP_JOY1: joystick_1 <= pay_data;
					OP_STATUS: begin
						if (pay_idx == IDX_W'(1))
							status[15:0] <= pay_data;
						else if (pay_idx == IDX_W'(2))
							status[31:16] <= pay_data;
					end
					OP_IMG_SIZE: begin
						// four words, least significant first
						case (pay_idx)
							IDX_W'(1): img_size[15:0] <= pay_data;
							IDX_W'(2): img_size[31:16] <= pay_data;
							IDX_W'(3): img_size[47:32] <= pay_data;
							IDX_W'(4): img_size[63:48] <= pay_data;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// byte for whichever queue is pushed
	always_ff @(posedge clk_sys) begin
		if (pay_valid)
			push_byte <= pay_data[7:0];
	end

	// a payload word feeds one ps2 queue at most
	a_one_push: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(kbd_push && mouse_push));

endmodule

//--- ps2/ps2_clk_div.sv
// shared ps2 clock source, gives both transmitters the bit clock and a tick on its rising edge
module ps2_clk_div (
	input logic clk_sys,
	input logic rst_n,
	output logic ps2_clk_int,
	output logic ps2_tick
);
	import hio_pkg::*;

	logic [PS2_CNT_W-1:0] div_cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ps2_clk_int <= 1'b0;
			ps2_tick <= 1'b0;
		end else begin
			ps2_tick <= 1'b0;
			if (div_cnt == PS2_CNT_W'(PS2_DIV - 1)) begin
				div_cnt <= '0;
				ps2_clk_int <= ~ps2_clk_int;
				// tick lines up with the low to high toggle
				if (!ps2_clk_int)
					ps2_tick <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

//--- ps2/ps2_tx.sv
// one ps2 device channel, queues host bytes and sends them as 11 bit device-to-host frames
module ps2_tx (
	input logic clk_sys,
	input logic rst_n,
	input logic push,
	input logic [7:0] push_byte,
	input logic ps2_clk_int,
	input logic ps2_tick,
	output logic ps2_clk,
	output logic ps2_data
);
	import hio_pkg::*;

	logic [7:0] fifo_mem [1<<PS2_FIFO_BITS];

	// extra pointer bit tells full from empty
	logic [PS2_FIFO_BITS:0] wptr;
	logic [PS2_FIFO_BITS:0] rptr;
	logic fifo_empty;
	logic fifo_full;

	// 0 idle, 1 start, 2..9 data, 10 parity, 11 stop
	logic [3:0] tx_state;
	logic [7:0] tx_byte;
	logic parity;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full = (wptr[PS2_FIFO_BITS] != rptr[PS2_FIFO_BITS]) &&
		(wptr[PS2_FIFO_BITS-1:0] == rptr[PS2_FIFO_BITS-1:0]);

	// clock only runs while a frame is on the line
	assign ps2_clk = ps2_clk_int | (tx_state == 4'd0);

	// write side, full drops the byte
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			wptr <= '0;
		else if (push && !fifo_full)
			wptr <= wptr + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (push && !fifo_full)
			fifo_mem[wptr[PS2_FIFO_BITS-1:0]] <= push_byte;
	end

	// serializer, data moves on the ps2 rising edge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rptr <= '0;
			tx_state <= 4'd0;
			parity <= 1'b1;
			ps2_data <= 1'b1;
		end else if (ps2_tick) begin
			if (tx_state == 4'd0) begin
				if (!fifo_empty) begin
					rptr <= rptr + 1'b1;
					// odd parity starts at one
					parity <= 1'b1;
					tx_state <= 4'd1;
					// start bit
					ps2_data <= 1'b0;
				end
			end else begin
				if (tx_state >= 4'd1 && tx_state < 4'd9) begin
					// lsb first
					ps2_data <= tx_byte[0];
					if (tx_byte[0])
						parity <= ~parity;
				end
				if (tx_state == 4'd9)
					ps2_data <= parity;
				// stop bit, also the idle level
				if (tx_state == 4'd10)
					ps2_data <= 1'b1;
				if (tx_state < 4'd11)
					tx_state <= tx_state + 1'b1;
				else
					tx_state <= 4'd0;
			end
		end
	end

	// shift register, loaded at start bit
	always_ff @(posedge clk_sys) begin
		if (ps2_tick) begin
			if (tx_state == 4'd0 && !fifo_empty)
				tx_byte <= fifo_mem[rptr[PS2_FIFO_BITS-1:0]];
			else if (tx_state >= 4'd1 && tx_state < 4'd9)
				tx_byte <= {1'b0, tx_byte[7:1]};
		end
	end

	a_state_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_state <= 4'd11);

endmodule

//--- download/ioctl_download.sv
// file download engine, turns host file commands into indexed byte writes on the ioctl port
module ioctl_download (
	input logic clk_sys,
	input logic rst_n,
	input logic pay_valid,
	input logic [hio_pkg::HIO_W-1:0] pay_data,
	input logic [7:0] opcode,
	output logic ioctl_download,
	output logic ioctl_wr,
	output logic [7:0] ioctl_index,
	output logic [hio_pkg::IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0] ioctl_dout
);
	import hio_pkg::*;

	// running address of the next byte
	logic [IOCTL_AW-1:0] addr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_wr <= 1'b0;
			ioctl_index <= '0;
			ioctl_addr <= '0;
			addr <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (pay_valid) begin
				case (opcode)
					OP_FILE_IDX: ioctl_index <= pay_data[7:0];
					OP_FILE_TX: begin
						if (pay_data[7:0] != 8'h00) begin
							// new download from address 0
							addr <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// end, addr shows the byte count
							ioctl_addr <= addr;
							ioctl_download <= 1'b0;
						end
					end
					OP_FILE_DAT: begin
						ioctl_addr <= addr;
						ioctl_wr <= 1'b1;
						// byte mode only, step one
						addr <= addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// write data, qualified by ioctl_wr
	always_ff @(posedge clk_sys) begin
		if (pay_valid && opcode == OP_FILE_DAT)
			ioctl_dout <= pay_data[7:0];
	end

	// host sends data only between the two file tx frames
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download);

endmodule

//--- verilog/hio_top.sv
// host io bridge top, connects the frame parser to the registers, ps2 channels and downloader
module hio_top (
	input logic clk_sys,
	input logic rst_n,
	input logic io_enable,
	input logic io_strobe,
	input logic [hio_pkg::HIO_W-1:0] io_din,
	output logic [hio_pkg::HIO_W-1:0] io_dout,
	output logic io_wait,
	input logic ioctl_wait,
	output logic [15:0] joystick_0,
	output logic [15:0] joystick_1,
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic [31:0] status,
	output logic img_mounted,
	output logic [63:0] img_size,
	output logic ioctl_download,
	output logic [7:0] ioctl_index,
	output logic ioctl_wr,
	output logic [hio_pkg::IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0] ioctl_dout,
	input logic [2:0] ps2_kbd_led_status,
	input logic [2:0] ps2_kbd_led_use,
	output logic ps2_kbd_clk,
	output logic ps2_kbd_data,
	output logic ps2_mouse_clk,
	output logic ps2_mouse_data
);
	import hio_pkg::*;

	logic pay_valid;
	logic frame_start;
	logic [HIO_W-1:0] pay_data;
	logic [IDX_W-1:0] pay_idx;
	logic [7:0] opcode;
	logic kbd_push;
	logic mouse_push;
	logic [7:0] push_byte;
	logic ps2_clk_int;
	logic ps2_tick;

	// core wait is the only back-pressure to the host
	assign io_wait = ioctl_wait;

	hio_cmd_frame u_frame (
		.clk_sys, .rst_n, .io_enable, .io_strobe, .io_din,
		.pay_valid, .frame_start, .pay_data, .pay_idx, .opcode
	);

	hio_regs u_regs (
		.clk_sys, .rst_n, .pay_valid, .frame_start, .pay_data, .pay_idx, .opcode,
		.kbd_led_status(ps2_kbd_led_status), .kbd_led_use(ps2_kbd_led_use),
		.buttons, .forced_scandoubler, .img_mounted, .joystick_0, .joystick_1,
		.status, .img_size, .io_dout, .kbd_push, .mouse_push, .push_byte
	);

	// one divider paces both channels
	ps2_clk_div u_ps2_div (.clk_sys, .rst_n, .ps2_clk_int, .ps2_tick);

	ps2_tx u_kbd (
		.clk_sys, .rst_n, .push(kbd_push), .push_byte, .ps2_clk_int, .ps2_tick,
		.ps2_clk(ps2_kbd_clk), .ps2_data(ps2_kbd_data)
	);

	ps2_tx u_mouse (
		.clk_sys, .rst_n, .push(mouse_push), .push_byte, .ps2_clk_int, .ps2_tick,
		.ps2_clk(ps2_mouse_clk), .ps2_data(ps2_mouse_data)
	);

	ioctl_download u_dl (
		.clk_sys, .rst_n, .pay_valid, .pay_data, .opcode,
		.ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout
	);

endmodule

//--- verification/hio_tb.sv
// table-driven testbench for the host io bridge, runs host frames and checks registers, ps2 and ioctl
module hio_tb;
	import hio_pkg::*;

	localparam int N_ENT = 20;
	localparam int TIMEOUT = N_ENT * 600;

	// what each table entry checks after its frame
	localparam int CHK_NONE = 0;
	localparam int CHK_CFG = 1;
	localparam int CHK_JOY0 = 2;
	localparam int CHK_JOY1 = 3;
	localparam int CHK_STATUS = 4;
	localparam int CHK_LED = 5;
	localparam int CHK_KBD = 6;
	localparam int CHK_MOUSE = 7;
	localparam int CHK_DL_INDEX = 8;
	localparam int CHK_DL_ACTIVE = 9;
	localparam int CHK_DL_DATA = 10;
	localparam int CHK_MOUNT = 11;
	localparam int CHK_IMG_SIZE = 12;

	logic clk_sys;
	logic rst_n;
	logic io_enable;
	logic io_strobe;
	logic [HIO_W-1:0] io_din;
	logic [HIO_W-1:0] io_dout;
	logic io_wait;
	logic ioctl_wait;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic [31:0] status;
	logic img_mounted;
	logic [63:0] img_size;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic [2:0] ps2_kbd_led_status;
	logic [2:0] ps2_kbd_led_use;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;
	logic ps2_mouse_clk;
	logic ps2_mouse_data;

	// stimulus table, one host frame per entry
	logic [7:0] ent_op [N_ENT];
	int ent_len [N_ENT];
	logic [15:0] ent_pay [N_ENT][4];
	int ent_chk [N_ENT];
	logic [63:0] ent_exp [N_ENT];
	// led use/status for read frames, wait hold cycles for data frames
	logic [5:0] ent_aux [N_ENT];
	int ent_cnt;

	// read words seen by the host before each next strobe
	logic [15:0] read_words [4];

	// expected traffic
	logic [7:0] kbd_exp [$];
	logic [7:0] mouse_exp [$];
	logic [IOCTL_AW-1:0] dl_addr_exp [$];
	logic [7:0] dl_data_exp [$];

	logic [10:0] ps2_frame [2];
	int ps2_nbits [2];
	int mount_count;
	int cycles;
	int value_errors;
	int other_errors;

	hio_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("error at %0t: %s", $time, what);
			other_errors++;
		end
	endtask

	task automatic add_entry(input logic [7:0] op, input int len,
		input logic [15:0] p0, p1, p2, p3, input int chk, input logic [63:0] exp,
		input logic [5:0] aux);
		ent_op[ent_cnt] = op;
		ent_len[ent_cnt] = len;
		ent_pay[ent_cnt][0] = p0;
		ent_pay[ent_cnt][1] = p1;
		ent_pay[ent_cnt][2] = p2;
		ent_pay[ent_cnt][3] = p3;
		ent_chk[ent_cnt] = chk;
		ent_exp[ent_cnt] = exp;
		ent_aux[ent_cnt] = aux;
		ent_cnt++;
	endtask

	task automatic build_table();
		logic [15:0] r0;
		logic [15:0] r1;
		logic [15:0] r2;
		logic [15:0] r3;
		ent_cnt = 0;
		// cfg bits 1:0 to buttons, bit 4 to scandoubler
		// expected is {scandoubler, buttons}
		r0 = 16'h0012;
		add_entry(OP_CFG, 1, r0, 16'h0, 16'h0, 16'h0, CHK_CFG, 64'h6, 6'd0);
		r0 = 16'h002D;
		add_entry(OP_CFG, 1, r0, 16'h0, 16'h0, 16'h0, CHK_CFG, 64'h1, 6'd0);
		r0 = 16'($urandom);
		add_entry(OP_JOY0, 1, r0, 16'h0, 16'h0, 16'h0, CHK_JOY0, 64'(r0), 6'd0);
		r0 = 16'($urandom);
		add_entry(OP_JOY1, 1, r0, 16'h0, 16'h0, 16'h0, CHK_JOY1, 64'(r0), 6'd0);
		add_entry(OP_STATUS, 2, 16'hBEEF, 16'h1234, 16'h0, 16'h0, CHK_STATUS,
			64'h1234_BEEF, 6'd0);
		// led reads, aux is {use, status}
		// status 011, use 101 gives 01 01 10 11
		add_entry(OP_KBD_LED, 2, 16'h0, 16'h0, 16'h0, 16'h0, CHK_LED,
			64'h5B, {3'b101, 3'b011});
		// status 110, use 010 gives 01 10 11 00
		add_entry(OP_KBD_LED, 1, 16'h0, 16'h0, 16'h0, 16'h0, CHK_LED,
			64'h6C, {3'b010, 3'b110});
		// all leds on and used
		add_entry(OP_KBD_LED, 3, 16'h0, 16'h0, 16'h0, 16'h0, CHK_LED,
			64'h7F, {3'b111, 3'b111});
		r0 = 16'($urandom);
		r1 = 16'($urandom);
		r2 = 16'($urandom);
		add_entry(OP_KBD, 3, r0, r1, r2, 16'h0, CHK_KBD, 64'h0, 6'd0);
		r0 = 16'($urandom);
		r1 = 16'($urandom);
		r2 = 16'($urandom);
		add_entry(OP_MOUSE, 3, r0, r1, r2, 16'h0, CHK_MOUSE, 64'h0, 6'd0);
		r0 = 16'($urandom);
		r1 = 16'($urandom);
		add_entry(OP_KBD, 2, r0, r1, 16'h0, 16'h0, CHK_KBD, 64'h0, 6'd0);
		// download, index then start, data in two frames, then stop
		add_entry(OP_FILE_IDX, 1, 16'h0003, 16'h0, 16'h0, 16'h0, CHK_DL_INDEX, 64'h3, 6'd0);
		add_entry(OP_FILE_TX, 1, 16'h0001, 16'h0, 16'h0, 16'h0, CHK_DL_ACTIVE, 64'h1, 6'd0);
		r0 = 16'($urandom);
		r1 = 16'($urandom);
		r2 = 16'($urandom);
		r3 = 16'($urandom);
		add_entry(OP_FILE_DAT, 4, r0, r1, r2, r3, CHK_DL_DATA, 64'h0, 6'd12);
		r0 = 16'($urandom);
		r1 = 16'($urandom);
		add_entry(OP_FILE_DAT, 2, r0, r1, 16'h0, 16'h0, CHK_DL_DATA, 64'h0, 6'd0);
		add_entry(OP_FILE_TX, 1, 16'h0000, 16'h0, 16'h0, 16'h0, CHK_DL_ACTIVE, 64'h0, 6'd0);
		add_entry(OP_MOUNT, 0, 16'h0, 16'h0, 16'h0, 16'h0, CHK_MOUNT, 64'h1, 6'd0);
		// image size, least significant word first
		add_entry(OP_IMG_SIZE, 4, 16'h0400, 16'h0002, 16'h0000, 16'h0001, CHK_IMG_SIZE,
			{16'h0001, 16'h0000, 16'h0002, 16'h0400}, 6'd0);
		// status frame cut after its low word, high half must stay
		add_entry(OP_STATUS, 1, 16'h5A5A, 16'h0, 16'h0, 16'h0, CHK_STATUS,
			64'h1234_5A5A, 6'd0);
		// first word after the break is a command again
		r0 = 16'($urandom);
		add_entry(OP_JOY1, 1, r0, 16'h0, 16'h0, 16'h0, CHK_JOY1, 64'(r0), 6'd0);
	endtask

	// one host frame, strobes four cycles apart
	task automatic send_frame(input int e);
		int k;
		io_enable <= 1'b1;
		@(posedge clk_sys);
		for (k = 0; k <= ent_len[e]; k++) begin
			while (io_wait)
				@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din <= (k == 0) ? {8'h00, ent_op[e]} : ent_pay[e][k-1];
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			repeat (3) @(posedge clk_sys);
			// host reads just before its next strobe
			if (k > 0)
				read_words[k-1] = io_dout;
		end
		io_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	// core wait must show on io_wait
	task automatic hold_wait(input int hold);
		ioctl_wait <= 1'b1;
		repeat (2) @(posedge clk_sys);
		check_value("io_wait", 64'(io_wait), 64'h1);
		repeat (hold) @(posedge clk_sys);
		ioctl_wait <= 1'b0;
		repeat (2) @(posedge clk_sys);
		check_value("io_wait", 64'(io_wait), 64'h0);
	endtask

	task automatic check_reset_state();
		check_value("img_mounted", 64'(img_mounted), 64'h0);
		check_value("ioctl_wr", 64'(ioctl_wr), 64'h0);
		check_value("ioctl_download", 64'(ioctl_download), 64'h0);
		check_value("io_dout", 64'(io_dout), 64'h0);
		check_value("buttons", 64'(buttons), 64'h0);
		check_value("forced_scandoubler", 64'(forced_scandoubler), 64'h0);
		check_value("joystick_0", 64'(joystick_0), 64'h0);
		check_value("joystick_1", 64'(joystick_1), 64'h0);
		check_value("status", 64'(status), 64'h0);
		check_value("img_size", img_size, 64'h0);
		check_true(ps2_kbd_clk & ps2_kbd_data, "keyboard ps2 lines not idle high after reset");
		check_true(ps2_mouse_clk & ps2_mouse_data, "mouse ps2 lines not idle high after reset");
	endtask

	// ps2 decoder, one bit per falling clock
	task automatic take_ps2_bit(input int ch, input logic b);
		logic [7:0] got;
		ps2_frame[ch][ps2_nbits[ch]] = b;
		ps2_nbits[ch]++;
		if (ps2_nbits[ch] == 11) begin
			ps2_nbits[ch] = 0;
			got = ps2_frame[ch][8:1];
			check_true(!ps2_frame[ch][0], "ps2 start bit not low");
			check_true(ps2_frame[ch][10], "ps2 stop bit not high");
			// data plus parity holds an odd count of ones
			check_true(^ps2_frame[ch][9:1], "ps2 parity not odd");
			if (ch == 0) begin
				check_true(kbd_exp.size() != 0, "keyboard ps2 byte sent with none queued");
				if (kbd_exp.size() != 0)
					check_value("ps2_kbd_data byte", 64'(got), 64'(kbd_exp.pop_front()));
			end else begin
				check_true(mouse_exp.size() != 0, "mouse ps2 byte sent with none queued");
				if (mouse_exp.size() != 0)
					check_value("ps2_mouse_data byte", 64'(got), 64'(mouse_exp.pop_front()));
			end
		end
	endtask

	always @(negedge ps2_kbd_clk) begin
		if (rst_n === 1'b1)
			take_ps2_bit(0, ps2_kbd_data);
	end

	always @(negedge ps2_mouse_clk) begin
		if (rst_n === 1'b1)
			take_ps2_bit(1, ps2_mouse_data);
	end

	// ioctl writes, mount pulses and the run limit
	always @(posedge clk_sys) begin
		if (rst_n === 1'b1 && ioctl_wr === 1'b1) begin
			check_true(ioctl_download, "ioctl write outside a download");
			check_true(dl_addr_exp.size() != 0, "ioctl write with no data byte sent");
			if (dl_addr_exp.size() != 0) begin
				check_value("ioctl_addr", 64'(ioctl_addr), 64'(dl_addr_exp.pop_front()));
				check_value("ioctl_dout", 64'(ioctl_dout), 64'(dl_data_exp.pop_front()));
			end
		end
		if (rst_n === 1'b1 && img_mounted === 1'b1)
			mount_count++;
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int i;
		int k;
		int mount_base;
		int dl_next;
		logic [15:0] exp_read;
		void'($urandom(56));
		value_errors = 0;
		other_errors = 0;
		mount_count = 0;
		cycles = 0;
		ps2_nbits[0] = 0;
		ps2_nbits[1] = 0;
		rst_n = 1'b0;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;
		ps2_kbd_led_status = '0;
		ps2_kbd_led_use = '0;
		build_table();
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		check_reset_state();
		dl_next = 0;
		for (i = 0; i < ent_cnt; i++) begin
			if (ent_chk[i] == CHK_LED) begin
				ps2_kbd_led_use <= ent_aux[i][5:3];
				ps2_kbd_led_status <= ent_aux[i][2:0];
			end
			// a nonzero start restarts the address
			if (ent_op[i] == OP_FILE_TX && ent_pay[i][0][7:0] != 8'h00)
				dl_next = 0;
			for (k = 0; k < ent_len[i]; k++) begin
				if (ent_chk[i] == CHK_KBD)
					kbd_exp.push_back(ent_pay[i][k][7:0]);
				if (ent_chk[i] == CHK_MOUSE)
					mouse_exp.push_back(ent_pay[i][k][7:0]);
				if (ent_chk[i] == CHK_DL_DATA) begin
					dl_addr_exp.push_back(IOCTL_AW'(dl_next));
					dl_data_exp.push_back(ent_pay[i][k][7:0]);
					dl_next++;
				end
			end
			if (ent_chk[i] == CHK_DL_DATA && ent_aux[i] != 6'd0)
				hold_wait(int'(ent_aux[i]));
			mount_base = mount_count;
			send_frame(i);
			// only led frames return a nonzero read word
			exp_read = (ent_chk[i] == CHK_LED) ? ent_exp[i][15:0] : 16'h0;
			for (k = 0; k < ent_len[i]; k++)
				check_value("io_dout", 64'(read_words[k]), 64'(exp_read));
			case (ent_chk[i])
				CHK_CFG: begin
					check_value("buttons", 64'(buttons), 64'(ent_exp[i][1:0]));
					check_value("forced_scandoubler", 64'(forced_scandoubler),
						64'(ent_exp[i][2]));
				end
				CHK_JOY0: check_value("joystick_0", 64'(joystick_0), ent_exp[i]);
				CHK_JOY1: check_value("joystick_1", 64'(joystick_1), ent_exp[i]);
				CHK_STATUS: check_value("status", 64'(status), ent_exp[i]);
				CHK_IMG_SIZE: check_value("img_size", img_size, ent_exp[i]);
				CHK_DL_INDEX: check_value("ioctl_index", 64'(ioctl_index), ent_exp[i]);
				CHK_DL_ACTIVE: check_value("ioctl_download", 64'(ioctl_download), ent_exp[i]);
				CHK_DL_DATA: check_true(dl_addr_exp.size() == 0, "ioctl write pulses missing");
				CHK_MOUNT: check_value("img_mounted pulses", 64'(mount_count - mount_base),
					ent_exp[i]);
				default: ;
			endcase
		end
		// drain both ps2 queues, then lines go idle
		while (kbd_exp.size() != 0 || mouse_exp.size() != 0)
			@(posedge clk_sys);
		repeat (4 * PS2_DIV) @(posedge clk_sys);
		check_true(ps2_kbd_clk & ps2_kbd_data, "keyboard ps2 lines not idle high");
		check_true(ps2_mouse_clk & ps2_mouse_data, "mouse ps2 lines not idle high");
		$display("checks done: %0d value mismatches, %0d other errors",
			value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- filelist.f
common/hio_pkg.sv
verilog/hio_cmd_frame.sv
verilog/hio_regs.sv
ps2/ps2_clk_div.sv
ps2/ps2_tx.sv
download/ioctl_download.sv
verilog/hio_top.sv
verification/hio_tb.sv

//--- Makefile
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module hio_tb -Mdir $(OBJ) -o hio_sim -f filelist.f

run: compile
	./$(OBJ)/hio_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf $(OBJ) sim.log
